//--- flist.f
hdl/aes_pkg.sv
hdl/wb_pkg.sv
hdl/aes_sbox.sv
hdl/aes_add_round_key.sv
hdl/aes_round.sv
hdl/aes_key_expand.sv
hdl/aes_core.sv
hdl/aes_wb_top.sv
sim/aes_wb_checker.sv
sim/aes_tb.sv

//--- hdl/aes_add_round_key.sv
/*
 * Add-round-key stage and state register of the round loop.
 * XORs state and round key when in_valid is high; result and out_valid
 * appear one clock later and the result holds until the next valid input.
 */
`timescale 1ns/1ps

module aes_add_round_key import aes_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       in_valid,
    input  aes_state_t state_in,
    input  aes_state_t round_key,
    output logic       out_valid,
    output aes_state_t state_out
);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            out_valid <= 1'b0;
            state_out <= '0;
        end
        else
        begin
            out_valid <= in_valid;              // one cycle pulse per input
            if (in_valid)
            begin
                for (int i = 0; i < 16; i++)
                    state_out[i] <= state_in[i] ^ round_key[i];    // bytewise
            end
        end
    end

endmodule

//--- hdl/aes_core.sv
/*
 * Iterative AES-128 encryption core, one round per clock.
 * start at cycle 0 whitens the plaintext, rounds 1 to 10 follow back to back
 * through the add-round-key register, done pulses with the result at cycle 11.
 * key and plain must stay stable while busy.
 */
`timescale 1ns/1ps

module aes_core import aes_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  aes_state_t key,
    input  aes_state_t plain,
    output logic       busy,
    output logic       done,
    output aes_state_t cipher
);

    logic [3:0] rnd;            // rounds already fed into the loop
    logic       start_ok;       // start seen while idle
    logic       feed;           // loop register holds a state that needs another round
    logic       final_round;
    logic       ark_in_valid;
    logic       ark_out_valid;
    logic       kx_load;
    logic       kx_step;
    aes_state_t ark_in;
    aes_state_t round_out;
    aes_state_t round_key;

    assign start_ok    = start && !busy;
    assign feed        = busy && ark_out_valid;
    assign final_round = (rnd + 4'd1 == 4'(aes_rounds));  // round about to be fed is 10

    assign ark_in_valid = start_ok || feed;
    assign ark_in       = feed ? round_out : plain;   // plaintext only for whitening

    // while idle the expander follows the key so round key 0 is ready at start
    assign kx_load = !busy && !start;
    assign kx_step = start_ok || (feed && !final_round);    // no key after round 10

    aes_add_round_key u_ark (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (ark_in_valid),
        .state_in  (ark_in),
        .round_key (round_key),
        .out_valid (ark_out_valid),
        .state_out (cipher)         // last value stays until the next start
    );

    aes_round u_round (
        .state_in    (cipher),
        .final_round (final_round),
        .state_out   (round_out)
    );

    aes_key_expand u_kexp (
        .clk        (clk),
        .resetn     (resetn),
        .load       (kx_load),
        .step       (kx_step),
        .master_key (key),
        .round_key  (round_key)
    );

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy <= 1'b0;
            done <= 1'b0;
            rnd  <= 4'd0;
        end
        else
        begin
            done <= 1'b0;                   // pulse by default
            if (start_ok)
            begin
                busy <= 1'b1;
                rnd  <= 4'd0;
            end
            else if (feed)
            begin
                rnd <= rnd + 4'd1;
                if (final_round)
                begin
                    busy <= 1'b0;           // result lands in the loop register now
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/aes_key_expand.sv
/*
 * On-the-fly AES-128 key schedule.
 * load copies the cipher key in and restarts the round constant sequence,
 * each step replaces round_key with the key of the following round.
 */
`timescale 1ns/1ps

module aes_key_expand import aes_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       load,
    input  logic       step,
    input  aes_state_t master_key,
    output aes_state_t round_key
);

    logic [3:0] rc_idx;         // steps taken since load, picks the rcon
    logic [7:0] sub_w [4];      // SubWord(RotWord(w3))
    logic [7:0] temp  [4];
    aes_state_t next_key;

    // rotated last word is bytes 13 14 15 12
    for (genvar g = 0; g < 4; g++)
    begin : g_subword
        aes_sbox u_sbox (
            .in  (round_key[12 + ((g + 1) % 4)]),
            .out (sub_w[g])
        );
    end

    always_comb
    begin
        temp[0] = sub_w[0] ^ aes_rcon[rc_idx];      // rcon only hits the top byte
        temp[1] = sub_w[1];
        temp[2] = sub_w[2];
        temp[3] = sub_w[3];
        // w0' = w0 ^ temp, then each word chains on the new one before it
        for (int b = 0; b < 4; b++)
            next_key[b] = round_key[b] ^ temp[b];
        for (int w = 1; w < 4; w++)
        begin
            for (int b = 0; b < 4; b++)
                next_key[4*w + b] = round_key[4*w + b] ^ next_key[4*(w - 1) + b];
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            round_key <= '0;
            rc_idx    <= 4'd0;
        end
        else if (load)
        begin
            round_key <= master_key;        // round 0 key is the cipher key
            rc_idx    <= 4'd0;
        end
        else if (step)
        begin
            round_key <= next_key;
            rc_idx    <= rc_idx + 4'd1;
        end
    end

endmodule

//--- hdl/aes_pkg.sv
/*
 * AES-128 definitions shared by the cipher datapath.
 * Holds the state type, the round count and the key schedule round constants.
 * Modules pull these in with a wildcard import in their header.
 */
package aes_pkg;

    // 16-byte state or round key
    // byte 0 is the first input byte and sits in bits 127:120,
    // so a 128-bit hex literal reads in FIPS-197 order
    // column c is bytes 4c .. 4c+3, row r of column c is byte 4c+r
    typedef logic [0:15][7:0] aes_state_t;

    // rounds for a 128-bit key
    localparam int aes_rounds = 10;

    // round constants for the key schedule, index is round number minus one
    localparam logic [0:9][7:0] aes_rcon = {
        8'h01,  // round 1
        8'h02,
        8'h04,
        8'h08,
        8'h10,
        8'h20,
        8'h40,
        8'h80,
        8'h1b,  // reduced by the field polynomial from here on
        8'h36   // round 10
    };

endpackage

//--- hdl/aes_round.sv
/*
 * One AES encryption round without the key addition.
 * SubBytes, ShiftRows and MixColumns, all combinational.
 * final_round skips MixColumns for round 10.
 */
`timescale 1ns/1ps

module aes_round import aes_pkg::*; (
    input  aes_state_t state_in,
    input  logic       final_round,
    output aes_state_t state_out
);

    // multiply by 2 in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // multiply by 3
    function automatic logic [7:0] mul3(input logic [7:0] b);
        return xtime(b) ^ b;
    endfunction

    logic [7:0] sub_b [16];     // after SubBytes
    aes_state_t shift_b;        // after ShiftRows
    aes_state_t mix_b;          // after MixColumns

    // SubBytes, one S-box per byte
    for (genvar g = 0; g < 16; g++)
    begin : g_sbox
        aes_sbox u_sbox (
            .in  (state_in[g]),
            .out (sub_b[g])
        );
    end

    // row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                shift_b[4*c + r] = sub_b[4*((c + r) % 4) + r];
        end
    end

    // each column times the fixed matrix 2 3 1 1
    always_comb
    begin
        logic [7:0] a0, a1, a2, a3;
        for (int c = 0; c < 4; c++)
        begin
            a0 = shift_b[4*c];
            a1 = shift_b[4*c + 1];
            a2 = shift_b[4*c + 2];
            a3 = shift_b[4*c + 3];
            mix_b[4*c]     = xtime(a0) ^ mul3(a1) ^ a2 ^ a3;
            mix_b[4*c + 1] = a0 ^ xtime(a1) ^ mul3(a2) ^ a3;
            mix_b[4*c + 2] = a0 ^ a1 ^ xtime(a2) ^ mul3(a3);
            mix_b[4*c + 3] = mul3(a0) ^ a1 ^ a2 ^ xtime(a3);
        end
    end

    assign state_out = final_round ? shift_b : mix_b;   // last round has no mix

endmodule

//--- hdl/aes_sbox.sv
/*
 * AES S-box as pure logic.
 * The field inverse goes through the GF(2^4) subfield by way of the norm x^17,
 * then the affine transform is applied. One instance per byte lane.
 */
`timescale 1ns/1ps

module aes_sbox (
    input  logic [7:0] in,
    output logic [7:0] out
);

    // multiply in GF(2^8) modulo x^8+x^4+x^3+x+1
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ sh;
            sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);   // xtime
        end
        return acc;
    endfunction

    logic [7:0] x2, x4, x8, x16;    // frobenius powers of the input
    logic [7:0] nrm;                // x^17, always inside GF(16)
    logic [7:0] n2, n4, n8;
    logic [7:0] nrm_inv;            // inverse inside the subfield
    logic [7:0] inv;                // x^-1, zero maps to zero

    assign x2  = gf_mul(in, in);
    assign x4  = gf_mul(x2, x2);
    assign x8  = gf_mul(x4, x4);
    assign x16 = gf_mul(x8, x8);
    assign nrm = gf_mul(x16, in);

    // y^-1 = y^14 for any nonzero y of GF(16)
    assign n2      = gf_mul(nrm, nrm);
    assign n4      = gf_mul(n2, n2);
    assign n8      = gf_mul(n4, n4);
    assign nrm_inv = gf_mul(gf_mul(n8, n4), n2);

    assign inv = gf_mul(nrm_inv, x16);     // x^16 / x^17

    // affine map, b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 63
    assign out = inv
               ^ {inv[6:0], inv[7]}
               ^ {inv[5:0], inv[7:6]}
               ^ {inv[4:0], inv[7:5]}
               ^ {inv[3:0], inv[7:4]}
               ^ 8'h63;

endmodule

//--- hdl/aes_wb_top.sv
/*
 * Wishbone classic slave around the AES-128 core.
 * Host writes key and plaintext words, sets ctrl bit 0, polls status
 * and reads the ciphertext words. ack comes one clock after cyc and stb.
 */
`timescale 1ns/1ps

module aes_wb_top import aes_pkg::*, wb_pkg::*; (
    input  logic             clk,
    input  logic             resetn,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [wb_aw-1:0] adr,
    input  logic [wb_dw-1:0] dat_w,
    output logic [wb_dw-1:0] dat_r,
    output logic             ack
);

    // pack state bytes 4n..4n+3 into a bus word, byte 4n on top
    function automatic logic [wb_dw-1:0] get_word(input aes_state_t s, input logic [1:0] n);
        logic [wb_dw-1:0] w;
        for (int b = 0; b < 4; b++)
            w[wb_dw-1-8*b -: 8] = s[4*n + b];
        return w;
    endfunction

    logic             acc;          // access taken on this edge
    logic             wr;
    logic [1:0]       widx;         // word within a 16-byte group
    logic             sel_key, sel_pt, sel_ct;
    logic             busy_any;
    logic             start_hit;
    logic             start_q;      // start pulse into the core
    logic             done_q;       // sticky done
    logic             core_busy;
    logic             core_done;
    logic [wb_dw-1:0] rd_mux;
    aes_state_t       key_r;
    aes_state_t       plain_r;
    aes_state_t       cipher;

    assign acc  = cyc && stb && !ack;
    assign wr   = acc && we;
    assign widx = adr[3:2];

    assign sel_key = (adr[wb_aw-1:4] == reg_key0[wb_aw-1:4]);
    assign sel_pt  = (adr[wb_aw-1:4] == reg_pt0[wb_aw-1:4]);
    assign sel_ct  = (adr[wb_aw-1:4] == reg_ct0[wb_aw-1:4]);

    assign busy_any  = core_busy || start_q;     // covers the cycle before core busy rises
    assign start_hit = wr && (adr == reg_ctrl) && dat_w[ctrl_start] && !busy_any;

    aes_core u_core (
        .clk    (clk),
        .resetn (resetn),
        .start  (start_q),
        .key    (key_r),
        .plain  (plain_r),
        .busy   (core_busy),
        .done   (core_done),
        .cipher (cipher)
    );

    // read data, zero for ctrl and unmapped offsets
    always_comb
    begin
        rd_mux = '0;
        if (sel_key)
            rd_mux = get_word(key_r, widx);
        else if (sel_pt)
            rd_mux = get_word(plain_r, widx);
        else if (sel_ct)
            rd_mux = get_word(cipher, widx);
        else if (adr == reg_status)
        begin
            rd_mux[stat_busy] = busy_any;
            rd_mux[stat_done] = done_q;
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            ack     <= 1'b0;
            dat_r   <= '0;
            start_q <= 1'b0;
            done_q  <= 1'b0;
            key_r   <= '0;
            plain_r <= '0;
        end
        else
        begin
            ack     <= acc;                 // single cycle, never back to back
            start_q <= start_hit;
            if (acc && !we)
                dat_r <= rd_mux;            // valid together with ack
            if (start_hit)
                done_q <= 1'b0;
            else if (core_done)
                done_q <= 1'b1;
            // key and plaintext are frozen while a block runs
            if (wr && !busy_any && (sel_key || sel_pt))
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (sel_key)
                        key_r[4*widx + b] <= dat_w[wb_dw-1-8*b -: 8];
                    else
                        plain_r[4*widx + b] <= dat_w[wb_dw-1-8*b -: 8];
                end
            end
        end
    end

endmodule

//--- hdl/wb_pkg.sv
/*
 * Wishbone bus widths and the register map of the AES slave.
 * Offsets are byte addresses, every access is a full 32-bit word.
 */
package wb_pkg;

    localparam int wb_dw = 32;              // data bus width
    localparam int wb_aw = 6;               // byte address width

    // register map
    localparam logic [wb_aw-1:0] reg_key0   = 6'h00;   // key words 0..3
    localparam logic [wb_aw-1:0] reg_pt0    = 6'h10;   // plaintext words 0..3
    localparam logic [wb_aw-1:0] reg_ctrl   = 6'h20;   // write only, reads zero
    localparam logic [wb_aw-1:0] reg_status = 6'h24;   // read only
    localparam logic [wb_aw-1:0] reg_ct0    = 6'h30;   // ciphertext words 0..3

    // control and status bits
    localparam int ctrl_start = 0;          // write 1 to launch a block
    localparam int stat_busy  = 0;          // block in flight
    localparam int stat_done  = 1;          // sticky, cleared by next start

endpackage

//--- sim/aes_tb.sv
/*
 * Testbench for the AES-128 Wishbone slave.
 * Reads key, plaintext and expected ciphertext per line from sim/aes_vectors.txt,
 * writes the words in shuffled order, starts the core, polls status, checks the result.
 */
`timescale 1ns/1ps

module aes_tb import wb_pkg::*;;

    localparam int ack_limit  = 8;      // cycles to wait for ack
    localparam int poll_limit = 40;     // status reads before giving up

    logic             clk;
    logic             resetn;
    logic             cyc;
    logic             stb;
    logic             we;
    logic [wb_aw-1:0] adr;
    logic [wb_dw-1:0] dat_w;
    logic [wb_dw-1:0] dat_r;
    logic             ack;

    integer       seed;
    integer       fd;
    int           vec_count;
    string        line;
    logic [127:0] key_v, pt_v, ct_v;
    logic [127:0] prev_ct;
    logic [31:0]  rd_w;

    aes_wb_top DUT (
        .clk    (clk),
        .resetn (resetn),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .ack    (ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    task automatic stop_run;
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("FAILED at %0t ns: %s, read %h expected %h", $time, what, actual, expected);
            stop_run;
        end
    endtask

    // ack is sampled on the falling edge, away from the DUT's clock edge
    task automatic wait_ack;
        int n;
        n = 0;
        @(negedge clk);
        while (!ack)
        begin
            n++;
            if (n > ack_limit)
            begin
                $display("slave never acknowledged the access to address %h", adr);
                stop_run;
            end
            @(negedge clk);
        end
    endtask

    // cyc stays high on return, the next access may follow back to back
    task automatic bus_write(input logic [wb_aw-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= addr;
        dat_w <= data;
        wait_ack;
    endtask

    task automatic bus_read(input logic [wb_aw-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= addr;
        wait_ack;
        data = dat_r;               // read data arrives with ack
    endtask

    task automatic idle_gap;
        int n;
        n = $unsigned($random(seed)) % 4;     // 0 to 3 idle cycles
        repeat (n)
        begin
            @(posedge clk);
            cyc <= 1'b0;
            stb <= 1'b0;
            we  <= 1'b0;
        end
    endtask

    // word n carries bytes 4n..4n+3, byte 4n in the top bits
    task automatic write_block(input logic [wb_aw-1:0] base, input logic [127:0] value);
        int order [4];
        int j;
        int tmp;
        for (int i = 0; i < 4; i++)
            order[i] = i;
        for (int i = 3; i > 0; i--)
        begin
            j        = $unsigned($random(seed)) % (i + 1);   // fisher-yates shuffle
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 4; i++)
        begin
            idle_gap;
            bus_write(base + 6'(4 * order[i]), value[127 - 32*order[i] -: 32]);
        end
    endtask

    task automatic check_block(input logic [wb_aw-1:0] base, input logic [127:0] expected,
                               input string what);
        logic [31:0] w;
        for (int n = 0; n < 4; n++)
        begin
            bus_read(base + 6'(4 * n), w);
            check_equal(w, expected[127 - 32*n -: 32], $sformatf("%s word %0d", what, n));
        end
    endtask

    task automatic wait_done;
        logic [31:0] st;
        int          polls;
        polls = 0;
        bus_read(reg_status, st);
        while (!st[stat_done])
        begin
            polls++;
            if (polls > poll_limit)
            begin
                $display("core never finished the block, done not set after %0d reads", polls);
                stop_run;
            end
            idle_gap;
            bus_read(reg_status, st);
        end
        check_equal(st, 32'(1) << stat_done, "status once done");    // busy gone too
    endtask

    initial
    begin
        seed      = 76;
        vec_count = 0;
        prev_ct   = '0;
        resetn    = 1'b0;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_w     = '0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;

        // idle state after reset
        bus_read(reg_status, rd_w);
        check_equal(rd_w, 32'h0, "status after reset");
        check_block(reg_ct0, 128'h0, "ciphertext after reset");

        fd = $fopen("sim/aes_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the vector file sim/aes_vectors.txt");
            stop_run;
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 32 || line[0] == "#")
                continue;                   // comment or blank line
            if ($sscanf(line, "%h %h %h", key_v, pt_v, ct_v) != 3)
            begin
                $display("malformed line in the vector file: %s", line);
                stop_run;
            end
            write_block(reg_key0, key_v);
            write_block(reg_pt0, pt_v);
            if (vec_count > 0)
            begin
                // new operands alone must not restart the core
                bus_read(reg_status, rd_w);
                check_equal(rd_w, 32'(1) << stat_done, "status before a fresh start");
                check_block(reg_ct0, prev_ct, "ciphertext before a fresh start");
            end
            check_block(reg_key0, key_v, "key readback");
            check_block(reg_pt0, pt_v, "plaintext readback");

            bus_write(reg_ctrl, 32'h1);
            bus_read(reg_status, rd_w);     // back to back, core still running
            check_equal(rd_w, 32'(1) << stat_busy, "status right after start");
            if (vec_count == 0)
            begin
                bus_write(reg_ctrl, 32'h1);                 // start while busy
                bus_write(reg_key0, ~key_v[127:96]);        // frozen while busy
                bus_write(reg_pt0 + 6'h4, $random(seed));
            end
            wait_done;
            check_block(reg_ct0, ct_v, $sformatf("ciphertext of vector %0d", vec_count));
            if (vec_count == 0)
            begin
                check_block(reg_key0, key_v, "key after writes while busy");
                check_block(reg_pt0, pt_v, "plaintext after writes while busy");
            end
            prev_ct = ct_v;
            vec_count++;
        end
        $fclose(fd);
        if (vec_count == 0)
        begin
            $display("vector file held no test lines");
            stop_run;
        end

        // unmapped offsets drop writes and read zero
        idle_gap;
        bus_write(6'h28, 32'hdeadbeef);
        bus_read(6'h28, rd_w);
        check_equal(rd_w, 32'h0, "unmapped read at 0x28");
        bus_read(6'h2c, rd_w);
        check_equal(rd_w, 32'h0, "unmapped read at 0x2c");

        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        repeat (2) @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

//--- sim/aes_vectors.txt
# AES-128 known answers, one test per line
# columns: key plaintext expected_ciphertext, 32 hex digits each, byte 0 first
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
00000000000000000000000000000000 9798c4640bad75c7c3227db910174e72 a9a1631bf4996954ebc093957b234589
00000000000000000000000000000000 80000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34

//--- sim/aes_wb_checker.sv
/*
 * Wishbone protocol and status bit assertions for the AES slave.
 * Bound into aes_wb_top at the end of this file, needs no testbench wiring.
 */
`timescale 1ns/1ps

module aes_wb_checker (
    input logic clk,
    input logic resetn,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic busy,           // status busy as the host sees it
    input logic done            // sticky done bit
);

    // ack only answers a live bus cycle
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!resetn)
        ack |-> (cyc && stb))
        else $error("ack high without cyc and stb");

    // single cycle ack, no back to back
    a_ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        ack |=> !ack)
        else $error("ack held high for two cycles");

    // reset keeps the slave quiet
    a_ack_in_reset: assert property (@(posedge clk)
        !resetn |-> !ack)
        else $error("ack high during reset");

    a_done_after_busy: assert property (@(posedge clk) disable iff (!resetn)
        $rose(done) |-> !busy)      // result only reported once the core is idle
        else $error("done bit rose while busy still set");

endmodule

bind aes_wb_top aes_wb_checker u_wb_checker (
    .clk    (clk),
    .resetn (resetn),
    .cyc    (cyc),
    .stb    (stb),
    .ack    (ack),
    .busy   (busy_any),
    .done   (done_q)
);
